// File: include/zxKbd_params.svh
`ifndef ZXKBD_PARAMS_SVH
`define ZXKBD_PARAMS_SVH

// ==============================
// Scan code buffer
// ==============================

`define SCAN_FIFO_DEPTH 8            // Entries held while the CPU side stalls

// ==============================
// PS/2 line conditioning
// ==============================

`define PS2_FILTER_LEN 4             // Equal samples needed to accept a new ps2Clk level

// Idle clocks before a half-received frame is thrown away
`define PS2_TIMEOUT_CYCLES 2000

`endif

// File: rtl/ps2Pkg.sv
package ps2Pkg;

    // ==============================
    // Receiver types
    // ==============================

    typedef logic [7:0] scanCode_t;       // One byte from the keyboard

    // Phase of the frame being shifted in
    typedef enum logic [1:0] {
        rxIdle,                           // Waiting for a start bit
        rxData,                           // Eight data bits, LSB first
        rxParity,                         // Odd parity bit
        rxStop                            // Stop bit, frame check
    } rxState_t;

    // ==============================
    // Prefix opcodes
    // ==============================

    // Codes that modify the meaning of the next code
    typedef enum logic [7:0] {
        prefixExtended = 8'hE0,           // Extended key follows
        prefixRelease  = 8'hF0            // Break code follows
    } ps2Prefix_t;

endpackage

// File: rtl/zxKeyPkg.sv
package zxKeyPkg;

    // ==============================
    // Key matrix types
    // ==============================

    // One half-row of the Spectrum keyboard
    typedef logic [4:0] keyRow_t;         // Active low, bit 0 is the outer key

    typedef logic [2:0] rowIndex_t;       // Selects one of the eight rows

    // ==============================
    // Decoder state
    // ==============================

    // Prefixes seen since the last plain code
    typedef enum logic [1:0] {
        decNormal,                        // No prefix pending
        decExtended,                      // E0 seen
        decReleased,                      // F0 seen
        decExtReleased                    // E0 and F0 seen
    } decodeState_t;

endpackage

// File: rtl/ps2Receiver.sv
`timescale 1ns/1ps
`include "zxKbd_params.svh"

module ps2Receiver (
    input  logic               clk,
    input  logic               reset,            // Active low
    input  logic               ps2Clk,           // Raw keyboard clock
    input  logic               ps2Data,          // Raw keyboard data
    output ps2Pkg::scanCode_t  scanCode,         // Valid with scanCodeReady
    output logic               scanCodeReady,    // One-cycle pulse per good frame
    output logic               scanCodeError     // One-cycle pulse per bad frame
);

    localparam int timeoutWidth = $clog2(`PS2_TIMEOUT_CYCLES);

    // ==============================
    // Line conditioning
    // ==============================

    logic [1:0]                 ps2ClkMeta;       // Two-flop synchronizer
    logic [1:0]                 ps2DataMeta;
    logic                       ps2ClkSync;
    logic                       ps2DataSync;
    logic [`PS2_FILTER_LEN-1:0] clkHistory;       // Recent synchronized clock samples
    logic                       ps2ClkFilt;       // Debounced clock level
    logic                       clkFall;          // Filtered falling edge

    assign ps2ClkSync  = ps2ClkMeta[1];
    assign ps2DataSync = ps2DataMeta[1];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ps2ClkMeta  <= 2'b11;                 // Lines idle high
            ps2DataMeta <= 2'b11;
            clkHistory  <= '1;
            ps2ClkFilt  <= 1'b1;
        end else begin
            ps2ClkMeta  <= {ps2ClkMeta[0], ps2Clk};
            ps2DataMeta <= {ps2DataMeta[0], ps2Data};
            clkHistory  <= {clkHistory[`PS2_FILTER_LEN-2:0], ps2ClkSync};
            if (&clkHistory)
                ps2ClkFilt <= 1'b1;               // Stable high
            else if (clkHistory == '0)
                ps2ClkFilt <= 1'b0;               // Stable low
        end
    end

    // Filter about to drop, so this is the sampling cycle
    assign clkFall = ps2ClkFilt && (clkHistory == '0);

    // ==============================
    // Frame state machine
    // ==============================

    ps2Pkg::rxState_t          state;
    logic [2:0]                bitCount;          // Data bit position
    logic                      startError;        // Start bit was high
    logic [timeoutWidth-1:0]   idleCount;         // Cycles since the last edge
    logic                      timedOut;
    ps2Pkg::scanCode_t         shiftReg;          // Data bits, LSB arrives first
    logic                      parityBit;
    logic                      frameBad;

    assign timedOut = (idleCount == timeoutWidth'(`PS2_TIMEOUT_CYCLES - 1));

    // Start, stop and odd parity checked together on the stop bit
    assign frameBad = startError || !ps2DataSync || !(^{shiftReg, parityBit});

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= ps2Pkg::rxIdle;
            bitCount      <= '0;
            startError    <= 1'b0;
            idleCount     <= '0;
            scanCodeReady <= 1'b0;
            scanCodeError <= 1'b0;
        end else begin
            scanCodeReady <= 1'b0;                // Pulses by default low
            scanCodeError <= 1'b0;

            if (clkFall || state == ps2Pkg::rxIdle)
                idleCount <= '0;
            else
                idleCount <= idleCount + 1'b1;

            if (clkFall) begin
                case (state)
                    ps2Pkg::rxIdle: begin
                        startError <= ps2DataSync;    // Start bit must be 0
                        bitCount   <= '0;
                        state      <= ps2Pkg::rxData;
                    end
                    ps2Pkg::rxData: begin
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7)
                            state <= ps2Pkg::rxParity;
                    end
                    ps2Pkg::rxParity: begin
                        state <= ps2Pkg::rxStop;
                    end
                    ps2Pkg::rxStop: begin
                        scanCodeError <= frameBad;
                        scanCodeReady <= !frameBad;
                        state         <= ps2Pkg::rxIdle;
                    end
                    default: state <= ps2Pkg::rxIdle;
                endcase
            end else if (timedOut) begin
                state <= ps2Pkg::rxIdle;          // Silent discard of a partial frame
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (clkFall && state == ps2Pkg::rxData)
            shiftReg <= {ps2DataSync, shiftReg[7:1]};
        if (clkFall && state == ps2Pkg::rxParity)
            parityBit <= ps2DataSync;
    end

    assign scanCode = shiftReg;

endmodule

// File: rtl/scanCodeFifo.sv
`timescale 1ns/1ps
`include "zxKbd_params.svh"

module scanCodeFifo (
    input  logic               clk,
    input  logic               reset,            // Active low
    input  ps2Pkg::scanCode_t  scanCode,
    input  logic               scanCodeReady,
    input  logic               scanCodeError,
    input  logic               cpuEnable,        // CPU clock enable, pops allowed
    output ps2Pkg::scanCode_t  entryCode,
    output logic               entryError,
    output logic               entryValid,       // One cycle per popped entry
    output logic               fifoOverflow      // Write lost on a full buffer
);

    localparam int ptrWidth   = $clog2(`SCAN_FIFO_DEPTH);
    localparam int countWidth = $clog2(`SCAN_FIFO_DEPTH + 1);

    logic [8:0]            mem [`SCAN_FIFO_DEPTH];   // {error, code}
    logic [ptrWidth-1:0]   readPtr;
    logic [ptrWidth-1:0]   writePtr;
    logic [countWidth-1:0] count;
    logic                  write;                    // Either receiver pulse
    logic                  full;
    logic                  popMem;                   // Take the oldest stored entry
    logic                  bypass;                   // Empty buffer, pass straight through
    logic                  store;

    assign write  = scanCodeReady || scanCodeError;
    assign full   = (count == countWidth'(`SCAN_FIFO_DEPTH));
    assign popMem = cpuEnable && (count != '0);
    assign bypass = cpuEnable && (count == '0) && write;
    assign store  = write && !bypass && (!full || popMem);   // Pop frees a slot

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            readPtr      <= '0;
            writePtr     <= '0;
            count        <= '0;
            entryValid   <= 1'b0;
            fifoOverflow <= 1'b0;
        end else begin
            entryValid   <= popMem || bypass;
            fifoOverflow <= write && full && !popMem;
            if (store)
                writePtr <= (writePtr == ptrWidth'(`SCAN_FIFO_DEPTH - 1)) ? '0 : writePtr + 1'b1;
            if (popMem)
                readPtr <= (readPtr == ptrWidth'(`SCAN_FIFO_DEPTH - 1)) ? '0 : readPtr + 1'b1;
            if (store && !popMem)
                count <= count + 1'b1;
            else if (popMem && !store)
                count <= count - 1'b1;
        end
    end

    // Storage and output payload
    always_ff @(posedge clk) begin
        if (store)
            mem[writePtr] <= {scanCodeError, scanCode};
        if (popMem)
            {entryError, entryCode} <= mem[readPtr];
        else if (bypass)
            {entryError, entryCode} <= {scanCodeError, scanCode};
    end

endmodule

// File: rtl/zxKeyMatrix.sv
`timescale 1ns/1ps

module zxKeyMatrix (
    input  logic               clk,
    input  logic               reset,            // Active low
    input  ps2Pkg::scanCode_t  entryCode,
    input  logic               entryError,       // Frame error, release all keys
    input  logic               entryValid,
    input  logic [15:0]        address,          // Row select in bits 15..8
    output zxKeyPkg::keyRow_t  keyRow
);

    zxKeyPkg::keyRow_t       keyState [8];       // Active low matrix
    zxKeyPkg::decodeState_t  decodeState;
    zxKeyPkg::keyRow_t       keyMask [8];        // Bits touched by this code
    logic [5:0]              keyCode;            // {row, bit} in octal
    logic                    keyHit;             // Code is on the map
    logic                    capsAlias;          // Backspace also holds CAPS SHIFT
    zxKeyPkg::rowIndex_t     hitRow;
    logic                    released;
    logic                    applyCode;

    // ==============================
    // PS/2 set 2 to Spectrum map
    // ==============================

    always_comb begin
        keyCode   = 6'o00;
        keyHit    = 1'b1;
        capsAlias = 1'b0;
        case (entryCode)
            8'h14: keyCode = 6'o00;          // Ctrl as CAPS SHIFT
            8'h12: keyCode = 6'o00;          // Left shift
            8'h59: keyCode = 6'o00;          // Right shift
            8'h1A: keyCode = 6'o01;          // Z
            8'h22: keyCode = 6'o02;          // X
            8'h21: keyCode = 6'o03;          // C
            8'h2A: keyCode = 6'o04;          // V
            8'h1C: keyCode = 6'o10;          // A
            8'h1B: keyCode = 6'o11;          // S
            8'h23: keyCode = 6'o12;          // D
            8'h2B: keyCode = 6'o13;          // F
            8'h34: keyCode = 6'o14;          // G
            8'h15: keyCode = 6'o20;          // Q
            8'h1D: keyCode = 6'o21;          // W
            8'h24: keyCode = 6'o22;          // E
            8'h2D: keyCode = 6'o23;          // R
            8'h2C: keyCode = 6'o24;          // T
            8'h16: keyCode = 6'o30;          // 1
            8'h1E: keyCode = 6'o31;          // 2
            8'h26: keyCode = 6'o32;          // 3
            8'h25: keyCode = 6'o33;          // 4
            8'h2E: keyCode = 6'o34;          // 5
            8'h45: keyCode = 6'o40;          // 0
            8'h46: keyCode = 6'o41;          // 9
            8'h3E: keyCode = 6'o42;          // 8
            8'h3D: keyCode = 6'o43;          // 7
            8'h36: keyCode = 6'o44;          // 6
            8'h4D: keyCode = 6'o50;          // P
            8'h44: keyCode = 6'o51;          // O
            8'h43: keyCode = 6'o52;          // I
            8'h3C: keyCode = 6'o53;          // U
            8'h35: keyCode = 6'o54;          // Y
            8'h5A: keyCode = 6'o60;          // Enter
            8'h4B: keyCode = 6'o61;          // L
            8'h42: keyCode = 6'o62;          // K
            8'h3B: keyCode = 6'o63;          // J
            8'h33: keyCode = 6'o64;          // H
            8'h29: keyCode = 6'o70;          // Space
            8'h11: keyCode = 6'o71;          // Alt as SYMBOL SHIFT
            8'h3A: keyCode = 6'o72;          // M
            8'h31: keyCode = 6'o73;          // N
            8'h32: keyCode = 6'o74;          // B
            8'h66: begin                     // Backspace is CAPS SHIFT + 0
                keyCode   = 6'o40;
                capsAlias = 1'b1;
            end
            default: keyHit = 1'b0;          // Unmapped code
        endcase
    end

    assign hitRow = keyCode[5:3];

    always_comb begin
        for (int r = 0; r < 8; r++)
            keyMask[r] = '0;
        if (keyHit)
            keyMask[hitRow][keyCode[2:0]] = 1'b1;
        if (capsAlias)
            keyMask[0][0] = 1'b1;
    end

    // ==============================
    // Prefix decoder and matrix update
    // ==============================

    assign released  = (decodeState == zxKeyPkg::decReleased);
    assign applyCode = (decodeState == zxKeyPkg::decNormal) || released;   // No E0 pending

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            decodeState <= zxKeyPkg::decNormal;
            for (int r = 0; r < 8; r++)
                keyState[r] <= '1;               // All keys up
        end else if (entryValid) begin
            if (entryError) begin
                decodeState <= zxKeyPkg::decNormal;
                for (int r = 0; r < 8; r++)
                    keyState[r] <= '1;           // No key left stuck
            end else if (entryCode == ps2Pkg::prefixExtended) begin
                if (released || decodeState == zxKeyPkg::decExtReleased)
                    decodeState <= zxKeyPkg::decExtReleased;
                else
                    decodeState <= zxKeyPkg::decExtended;
            end else if (entryCode == ps2Pkg::prefixRelease) begin
                if (decodeState == zxKeyPkg::decExtended ||
                    decodeState == zxKeyPkg::decExtReleased)
                    decodeState <= zxKeyPkg::decExtReleased;
                else
                    decodeState <= zxKeyPkg::decReleased;
            end else begin
                decodeState <= zxKeyPkg::decNormal;
                if (applyCode) begin
                    for (int r = 0; r < 8; r++)
                        keyState[r] <= released ? (keyState[r] | keyMask[r])
                                                : (keyState[r] & ~keyMask[r]);
                end
            end
        end
    end

    // ==============================
    // Row read for IN from port FE
    // ==============================

    logic [3:0]          zeroCount;              // Zeros in the upper address byte
    zxKeyPkg::rowIndex_t readIndex;

    always_comb begin
        zeroCount = '0;
        readIndex = '0;
        for (int i = 0; i < 8; i++) begin
            if (!address[8 + i]) begin
                zeroCount = zeroCount + 4'd1;
                readIndex = zxKeyPkg::rowIndex_t'(i);
            end
        end
        keyRow = (zeroCount == 4'd1) ? keyState[readIndex] : '1;   // Single row only
    end

endmodule

// File: rtl/zxKeyboardTop.sv
`timescale 1ns/1ps

module zxKeyboardTop (
    input  logic               clk,
    input  logic               reset,            // Asynchronous, active low
    input  logic               ps2Clk,
    input  logic               ps2Data,
    input  logic               cpuEnable,        // CPU domain clock enable
    input  logic [15:0]        address,          // CPU address bus
    output zxKeyPkg::keyRow_t  keyRow,           // Row answer for IN from FE
    output logic               fifoOverflow      // Scan code lost
);

    // ==============================
    // Receiver to FIFO
    // ==============================

    ps2Pkg::scanCode_t scanCode;
    logic              scanCodeReady;
    logic              scanCodeError;

    ps2Receiver receiver (
        .clk           (clk),
        .reset         (reset),
        .ps2Clk        (ps2Clk),
        .ps2Data       (ps2Data),
        .scanCode      (scanCode),
        .scanCodeReady (scanCodeReady),
        .scanCodeError (scanCodeError)
    );

    // ==============================
    // FIFO to matrix
    // ==============================

    ps2Pkg::scanCode_t entryCode;
    logic              entryError;
    logic              entryValid;

    scanCodeFifo fifo (
        .clk           (clk),
        .reset         (reset),
        .scanCode      (scanCode),
        .scanCodeReady (scanCodeReady),
        .scanCodeError (scanCodeError),
        .cpuEnable     (cpuEnable),
        .entryCode     (entryCode),
        .entryError    (entryError),
        .entryValid    (entryValid),
        .fifoOverflow  (fifoOverflow)
    );

    zxKeyMatrix matrix (
        .clk        (clk),
        .reset      (reset),
        .entryCode  (entryCode),
        .entryError (entryError),
        .entryValid (entryValid),
        .address    (address),
        .keyRow     (keyRow)
    );

endmodule

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    // ==============================
    // 4 ns period, starts low
    // ==============================

    initial clk = 1'b0;

    always #2 clk = ~clk;                    // Half period 2 ns

endmodule

// File: tests/zxKeyboardTb.sv
`timescale 1ns/1ps
`include "zxKbd_params.svh"

module zxKeyboardTb;

    localparam int halfBit     = 20;         // Clocks per PS/2 half bit
    localparam int settleLimit = 200;        // Polling limit per settle wait

    logic              clk;
    logic              reset;
    logic              ps2Clk;
    logic              ps2Data;
    logic              cpuEnable;
    logic [15:0]       address;
    zxKeyPkg::keyRow_t keyRow;
    logic              fifoOverflow;

    tbClock clockGen (.clk(clk));

    zxKeyboardTop dut (
        .clk          (clk),
        .reset        (reset),
        .ps2Clk       (ps2Clk),
        .ps2Data      (ps2Data),
        .cpuEnable    (cpuEnable),
        .address      (address),
        .keyRow       (keyRow),
        .fifoOverflow (fifoOverflow)
    );

    // ==============================
    // Reference key model
    // ==============================

    // Spectrum layout in set 2 codes with index row * 5 + bit
    localparam logic [7:0] keyTable [40] = '{
        8'h12, 8'h1A, 8'h22, 8'h21, 8'h2A,   // CAPS Z X C V
        8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34,   // A S D F G
        8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C,   // Q W E R T
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,   // 1 2 3 4 5
        8'h45, 8'h46, 8'h3E, 8'h3D, 8'h36,   // 0 9 8 7 6
        8'h4D, 8'h44, 8'h43, 8'h3C, 8'h35,   // P O I U Y
        8'h5A, 8'h4B, 8'h42, 8'h3B, 8'h33,   // ENTER L K J H
        8'h29, 8'h11, 8'h3A, 8'h31, 8'h32    // SPACE SYM M N B
    };

    logic [4:0] modelRows [8];               // Active low as in the matrix
    logic       modelExt;                    // E0 pending
    logic       modelRel;                    // F0 pending
    logic [8:0] pendingQueue [$];            // {error, code} held while cpuEnable is low
    int         droppedCodes = 0;            // Writes the model expects to be lost
    int         overflowCount = 0;           // fifoOverflow pulses seen
    int         errorCount = 0;
    int         checkCount = 0;
    int         testsRun = 0;
    int         testsFailed = 0;
    int         testStartErrors = 0;

    // Position of a code on the matrix or -1 when unmapped
    function automatic int keyIndex(input logic [7:0] code);
        int idx;
        idx = -1;
        for (int i = 0; i < 40; i++)
            if (keyTable[i] == code)
                idx = i;
        if (code == 8'h59 || code == 8'h14)  // Right shift and Ctrl alias CAPS
            idx = 0;
        return idx;
    endfunction

    task automatic modelApply(input logic [7:0] code, input logic err);
        int idx;
        idx = keyIndex(code);
        if (err) begin
            for (int r = 0; r < 8; r++)
                modelRows[r] = 5'h1F;        // Frame error releases everything
            modelExt = 1'b0;
            modelRel = 1'b0;
        end else if (code == 8'hE0) begin
            modelExt = 1'b1;
        end else if (code == 8'hF0) begin
            modelRel = 1'b1;
        end else begin
            if (!modelExt) begin             // Extended keys are ignored
                if (code == 8'h66) begin     // Backspace acts as CAPS + 0
                    modelRows[0][0] = modelRel;
                    modelRows[4][0] = modelRel;
                end else if (idx >= 0) begin
                    modelRows[idx / 5][idx % 5] = modelRel;
                end
            end
            modelExt = 1'b0;
            modelRel = 1'b0;
        end
    endtask

    // Expected keyRow is 1F unless bits 15..8 hold exactly one zero
    function automatic logic [4:0] expectedRow(input logic [15:0] addr);
        int zeros;
        int row;
        zeros = 0;
        row   = 0;
        for (int i = 0; i < 8; i++) begin
            if (!addr[8 + i]) begin
                zeros++;
                row = i;
            end
        end
        if (zeros == 1)
            return modelRows[row];
        return 5'h1F;
    endfunction

    function automatic logic [15:0] rowAddress(input int row);
        return {~(8'h01 << row), 8'hFE};     // IN from port FE
    endfunction

    // ==============================
    // PS/2 driver
    // ==============================

    task automatic sendFrame(input logic [7:0] code, input logic badParity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code;                     // Odd parity over data and parity
        if (badParity)
            parity = ~parity;
        frame = {1'b1, parity, code, 1'b0};  // Stop, parity, data, start
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2Data <= frame[i];             // Data changes while clock is high
            repeat (halfBit) @(posedge clk);
            ps2Clk <= 1'b0;
            repeat (halfBit) @(posedge clk);
            ps2Clk <= 1'b1;
        end
        repeat (halfBit) @(posedge clk);     // Idle gap
    endtask

    // Send a frame and feed the model, or queue it while the CPU side stalls
    task automatic typeCode(input logic [7:0] code, input logic badParity);
        sendFrame(code, badParity);
        if (cpuEnable)
            modelApply(code, badParity);
        else if (pendingQueue.size() < `SCAN_FIFO_DEPTH)
            pendingQueue.push_back({badParity, code});
        else
            droppedCodes++;                  // Entry lost on a full FIFO
    endtask

    task automatic releaseCode(input logic [7:0] code);
        typeCode(8'hF0, 1'b0);
        typeCode(code, 1'b0);
    endtask

    task automatic drainQueue();
        logic [8:0] entry;
        while (pendingQueue.size() > 0) begin
            entry = pendingQueue.pop_front();
            modelApply(entry[7:0], entry[8]);
        end
    endtask

    // ==============================
    // Compare and settle
    // ==============================

    always @(negedge clk) begin
        if (fifoOverflow)
            overflowCount++;
    end

    task automatic compareMatrix();
        logic [15:0] addr;
        logic [4:0]  expected;
        for (int i = 0; i < 9; i++) begin
            addr = (i < 8) ? rowAddress(i) : 16'h7EFE;   // Last one has two zeros
            @(posedge clk);
            address <= addr;
            @(negedge clk);                  // keyRow stable mid cycle
            expected = expectedRow(addr);
            checkCount++;
            if (keyRow !== expected) begin
                $display("** Error: keyRow at address %h is %h, expected %h",
                         addr, keyRow, expected);
                errorCount++;
            end
        end
    endtask

    // Poll until a full sweep matches the model
    task automatic settleMatrix();
        int          matched;
        int          cycles;
        int          slot;
        logic [15:0] addr;
        matched = 0;
        cycles  = 0;
        slot    = 0;
        while (matched < 9 && cycles < settleLimit) begin
            addr = (slot < 8) ? rowAddress(slot) : 16'h7EFE;
            @(posedge clk);
            address <= addr;
            @(negedge clk);
            if (keyRow === expectedRow(addr))
                matched++;
            else
                matched = 0;
            slot = (slot + 1) % 9;
            cycles++;
        end
        if (matched < 9) begin
            $display("Timeout: the key matrix did not reach the model state within %0d cycles",
                     settleLimit);
            errorCount++;
        end
    endtask

    task automatic settleAndCompare();
        settleMatrix();
        compareMatrix();
    endtask

    task automatic checkKeyBit(input int row, input int bitPos, input logic expected);
        logic [15:0] addr;
        addr = rowAddress(row);
        @(posedge clk);
        address <= addr;
        @(negedge clk);
        checkCount++;
        if (keyRow[bitPos] !== expected) begin
            $display("** Error: keyRow[%0d] at address %h is %h, expected %h",
                     bitPos, addr, keyRow[bitPos], expected);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        int failures;
        failures = errorCount - testStartErrors;
        testsRun++;
        if (failures == 0) begin
            $display("Test %0d %s: ok", testsRun, name);
        end else begin
            $display("Test %0d %s: %0d errors", testsRun, name, failures);
            testsFailed++;
        end
        testStartErrors = errorCount;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        logic [7:0] picks [6];
        logic [7:0] aliases [3];

        reset     = 1'b0;
        ps2Clk    = 1'b1;                    // Lines idle high
        ps2Data   = 1'b1;
        cpuEnable = 1'b1;
        address   = 16'hFFFF;
        for (int r = 0; r < 8; r++)
            modelRows[r] = 5'h1F;
        modelExt = 1'b0;
        modelRel = 1'b0;
        aliases  = '{8'h12, 8'h59, 8'h14};   // Both shifts and Ctrl
        void'($urandom(32'hc30));

        repeat (10) @(posedge clk);
        reset <= 1'b1;

        // Test 1 checks the reset state
        compareMatrix();
        finishTest("reset state");

        // Test 2 runs random makes and breaks and then the CAPS aliases
        for (int n = 0; n < 6; n++)
            picks[n] = keyTable[$urandom % 40];
        for (int n = 0; n < 6; n++)
            typeCode(picks[n], 1'b0);
        settleAndCompare();
        for (int n = 0; n < 6; n++)
            releaseCode(picks[n]);
        settleAndCompare();
        for (int n = 0; n < 3; n++) begin
            typeCode(aliases[n], 1'b0);
            settleAndCompare();
            checkKeyBit(0, 0, 1'b0);         // CAPS SHIFT held
            releaseCode(aliases[n]);
            settleAndCompare();
        end
        finishTest("make and break");

        // Test 3 shows extended codes being ignored
        typeCode(8'hE0, 1'b0);
        typeCode(8'h1A, 1'b0);               // Z stays up after an extended make
        settleAndCompare();
        typeCode(8'h1A, 1'b0);               // Plain Z applies
        settleAndCompare();
        typeCode(8'hE0, 1'b0);
        typeCode(8'hF0, 1'b0);
        typeCode(8'h1A, 1'b0);               // Z stays held through an extended break
        settleAndCompare();
        releaseCode(8'h1A);
        settleAndCompare();
        finishTest("extended prefix");

        // Test 4 covers backspace
        typeCode(8'h66, 1'b0);
        settleAndCompare();
        checkKeyBit(0, 0, 1'b0);
        checkKeyBit(4, 0, 1'b0);
        releaseCode(8'h66);
        settleAndCompare();
        checkKeyBit(0, 0, 1'b1);
        checkKeyBit(4, 0, 1'b1);
        finishTest("backspace");

        // Test 5 lets a parity error release held keys
        typeCode(8'h15, 1'b0);               // Q
        typeCode(8'h2E, 1'b0);               // 5
        typeCode(8'h29, 1'b0);               // Space
        settleAndCompare();
        typeCode(8'h16, 1'b1);
        settleAndCompare();
        finishTest("frame error");

        // Test 6 stalls the CPU side, resumes it and overflows the FIFO
        @(posedge clk);
        cpuEnable <= 1'b0;
        typeCode(8'h1C, 1'b0);               // A
        typeCode(8'h4D, 1'b0);               // P
        typeCode(8'h5A, 1'b0);               // Enter
        releaseCode(8'h1C);                  // Final state of A depends on order
        compareMatrix();                     // Nothing applied yet
        @(posedge clk);
        cpuEnable <= 1'b1;
        drainQueue();
        settleAndCompare();
        releaseCode(8'h1C);
        releaseCode(8'h4D);
        releaseCode(8'h5A);
        settleAndCompare();
        @(posedge clk);
        cpuEnable <= 1'b0;
        for (int n = 1; n <= `SCAN_FIFO_DEPTH + 2; n++)
            typeCode(keyTable[n], 1'b0);     // Two more than the FIFO holds
        compareMatrix();
        @(posedge clk);
        cpuEnable <= 1'b1;
        drainQueue();
        settleAndCompare();
        checkCount++;
        if (overflowCount != droppedCodes) begin
            $display("** Error: fifoOverflow pulse count is %h, expected %h",
                     overflowCount, droppedCodes);
            errorCount++;
        end
        finishTest("back-pressure");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
rtl/ps2Pkg.sv
rtl/zxKeyPkg.sv
rtl/ps2Receiver.sv
rtl/scanCodeFifo.sv
rtl/zxKeyMatrix.sv
rtl/zxKeyboardTop.sv
tests/tbClock.sv
tests/zxKeyboardTb.sv

// File: Makefile
# Verilator build and run of the keyboard testbench

SIM = obj_dir/zxKeyboardSim

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module zxKeyboardTb \
		-Mdir obj_dir -o zxKeyboardSim

run: compile
	./$(SIM) | tee run.log
	grep -q "TESTS PASSED" run.log

clean:
	rm -rf obj_dir run.log
